//--- files.f
+incdir+source
source/cpu_pkg.sv
source/fetcher.sv
source/decoder.sv
source/regfile.sv
source/execute.sv
source/memctrl.sv
source/cpu.sv
test/cpu_tb.sv

//--- test/cpu_tb.sv
/* testbench for the RV32I subset core
   byte memory and uart model, reference ISA model, store comparator, watchdog */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

    localparam int MEM_BYTES     = 1 << 17;
    localparam int CYC_PER_INSTR = 24;
    localparam int PAUSE_FACTOR  = 2;
    localparam int MARGIN        = 4;
    localparam int OPIMM         = 7'h13;
    localparam int LOAD          = 7'h03;

    // one expected store, a word for memory or a low byte for I/O
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_rec_t;

    logic        clk_in;
    logic        arst_n;
    logic        rdy_in;
    logic        io_buffer_full;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic [31:0] dbgreg_dout;

    logic [7:0]  mem [MEM_BYTES];
    logic [7:0]  ref_mem [MEM_BYTES];
    store_rec_t  exp_q [$];
    logic [31:0] ref_x10;
    int          n_steps;
    logic        model_done = 1'b0;
    logic        stop_seen = 1'b0;
    logic [31:0] rnd = 32'h0685efb6;
    logic [31:0] rd_addr = '0;
    logic [31:0] word_addr;
    logic [31:0] word_buf;
    int          byte_cnt = 0;

    cpu dut_i (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .rdy_in         (rdy_in),
        .mem_din        (mem_din),
        .mem_dout       (mem_dout),
        .mem_a          (mem_a),
        .mem_wr         (mem_wr),
        .io_buffer_full (io_buffer_full),
        .dbgreg_dout    (dbgreg_dout)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // instruction word builders
    function automatic logic [31:0] rtype(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] itype(int opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] stype(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] btype(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] utype(int rd, int imm);
        return {imm[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] jtype(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic load_program();
        logic [31:0] prog [$];
        prog = '{
            utype(1, 20'h12345), itype(OPIMM, 0, 1, 1, 12'h678),
            utype(6, 20'h00001), utype(5, 20'h00030),
            itype(OPIMM, 0, 2, 0, -5), itype(OPIMM, 0, 4, 0, 4),
            rtype(0, 0, 3, 1, 2), stype(3, 6, 0),
            rtype(7'h20, 0, 3, 1, 2), stype(3, 6, 4),
            rtype(0, 7, 3, 1, 2), rtype(0, 6, 12, 1, 4), rtype(0, 4, 13, 1, 2),
            stype(3, 6, 8), stype(12, 6, 12), stype(13, 6, 16),
            rtype(0, 2, 3, 2, 4), rtype(0, 2, 12, 4, 2),
            rtype(0, 1, 13, 1, 4), rtype(0, 5, 14, 2, 4),
            stype(3, 6, 20), stype(12, 6, 24), stype(13, 6, 28), stype(14, 6, 32),
            itype(OPIMM, 7, 3, 1, 12'h0f0), itype(OPIMM, 6, 12, 1, -256),
            itype(OPIMM, 4, 13, 2, 12'h555), itype(OPIMM, 2, 14, 2, -4),
            itype(OPIMM, 1, 15, 1, 7), itype(OPIMM, 5, 16, 2, 9),
            stype(3, 6, 36), stype(12, 6, 40), stype(13, 6, 44),
            stype(14, 6, 48), stype(15, 6, 52), stype(16, 6, 56),
            itype(LOAD, 2, 10, 6, 4), rtype(0, 0, 10, 10, 13),
            stype(10, 6, 60), itype(LOAD, 2, 11, 6, 60),
            itype(OPIMM, 0, 7, 0, 5), itype(OPIMM, 0, 8, 0, 12'h040),
            // countdown loop sending bytes to the uart
            rtype(0, 0, 8, 8, 7), stype(8, 5, 0),
            itype(OPIMM, 0, 7, 7, -1), btype(1, 7, 0, -12),
            btype(0, 7, 8, 8), stype(11, 6, 64),
            btype(0, 7, 0, 8), stype(1, 5, 0),
            jtype(9, 8), stype(2, 6, 68),
            stype(9, 6, 68), rtype(0, 0, 10, 10, 9),
            stype(0, 5, 4), jtype(0, 0)
        };
        foreach (prog[i])
            {mem[4*i+3], mem[4*i+2], mem[4*i+1], mem[4*i]} = prog[i];
    endtask

    function automatic logic [31:0] ref_word(logic [31:0] addr);
        return {ref_mem[addr[16:0] + 17'd3], ref_mem[addr[16:0] + 17'd2],
                ref_mem[addr[16:0] + 17'd1], ref_mem[addr[16:0]]};
    endfunction

    // instruction-set model, fills exp_q and returns the final x10
    function automatic logic [31:0] run_model();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next_pc;
        logic        wr;
        logic        done;
        pc      = `RESET_PC;
        done    = 1'b0;
        n_steps = 0;
        foreach (x[i])
            x[i] = '0;
        while (!done && n_steps < 10000) begin
            ins     = ref_word(pc);
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            res     = '0;
            case (ins[6:0])
                7'h37: begin
                    res = {ins[31:12], 12'h000};
                    wr  = 1'b1;
                end
                7'h13, 7'h33: begin
                    if (!ins[5])
                        b = {{20{ins[31]}}, ins[31:20]};
                    wr = 1'b1;
                    case (ins[14:12])
                        3'd0:    res = (ins[5] && ins[30]) ? a - b : a + b;
                        3'd1:    res = a << b[4:0];
                        3'd2:    res = {31'd0, $signed(a) < $signed(b)};
                        3'd4:    res = a ^ b;
                        3'd5:    res = a >> b[4:0];
                        3'd6:    res = a | b;
                        default: res = a & b;
                    endcase
                end
                7'h03: begin
                    res = ref_word(a + {{20{ins[31]}}, ins[31:20]});
                    wr  = 1'b1;
                end
                7'h23: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (addr[17:16] == 2'b11) begin
                        exp_q.push_back(store_rec_t'{addr, b});
                        done = addr == `IO_STOP_ADDR;
                    end else begin
                        for (int k = 0; k < 4; k++)
                            ref_mem[addr[16:0] + 17'(k)] = b[8*k +: 8];
                        exp_q.push_back(store_rec_t'{addr, b});
                    end
                end
                7'h63: begin
                    if ((a == b) != ins[12])
                        next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
                7'h6f: begin
                    res     = pc + 32'd4;
                    wr      = 1'b1;
                    next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0)
                x[ins[11:7]] = res;
            pc = next_pc;
            n_steps++;
        end
        return x[10];
    endfunction

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // random pauses and uart back-pressure, plus read data for last cycle's address
    always @(posedge clk_in) begin
        #1;
        rnd            = lcg_next(rnd);
        rdy_in         = rnd[31:30] != 2'b00;
        io_buffer_full = rnd[29:28] == 2'b00;
        mem_din        = mem[rd_addr[16:0]];
    end

    // bus monitor and store comparator
    always @(negedge clk_in) begin
        store_rec_t want;
        rd_addr = mem_a;
        if (arst_n) begin
            assert (rdy_in || !mem_wr) else begin
                $display("mem_wr was high while rdy_in was low at %0t", $time);
                $display("Finished with errors");
                $fatal(1);
            end
            if (rdy_in && mem_wr) begin
                assert (exp_q.size() != 0) else begin
                    $display("a store appeared after all expected stores at %0t", $time);
                    $display("Finished with errors");
                    $fatal(1);
                end
                if (mem_a >= `IO_BASE) begin
                    assert (!io_buffer_full) else begin
                        $display("I/O write while io_buffer_full was high at %0t", $time);
                        $display("Finished with errors");
                        $fatal(1);
                    end
                    want = exp_q.pop_front();
                    assert (mem_a == want.addr && mem_dout == want.data[7:0]) else begin
                        $display("[ERROR] mem_a/mem_dout expected %h/%h got %h/%h",
                                 want.addr, want.data[7:0], mem_a, mem_dout);
                        $display("Finished with errors");
                        $fatal(1);
                    end
                    if (mem_a == `IO_STOP_ADDR)
                        stop_seen = 1'b1;
                end else begin
                    mem[mem_a[16:0]] = mem_dout;
                    if (byte_cnt == 0)
                        word_addr = mem_a;
                    assert (mem_a == word_addr + 32'(byte_cnt)) else begin
                        $display("[ERROR] mem_a expected %h got %h",
                                 word_addr + 32'(byte_cnt), mem_a);
                        $display("Finished with errors");
                        $fatal(1);
                    end
                    word_buf[8*byte_cnt +: 8] = mem_dout;
                    byte_cnt++;
                    // a full word is in, compare with the next model store
                    if (byte_cnt == 4) begin
                        byte_cnt = 0;
                        want     = exp_q.pop_front();
                        assert (word_addr == want.addr && word_buf == want.data) else begin
                            $display("[ERROR] mem_a/mem_dout word expected %h/%h got %h/%h",
                                     want.addr, want.data, word_addr, word_buf);
                            $display("Finished with errors");
                            $fatal(1);
                        end
                    end
                end
            end
        end
    end

    initial begin
        wait (model_done);
        repeat (n_steps * CYC_PER_INSTR * PAUSE_FACTOR * MARGIN) @(posedge clk_in);
        $display("timeout, the program never stored to the stop address");
        $display("Finished with errors");
        $fatal(1);
    end

    initial begin
        arst_n         = 1'b0;
        rdy_in         = 1'b0;
        io_buffer_full = 1'b0;
        mem_din        = 8'h00;
        for (int i = 0; i < MEM_BYTES; i++)
            mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16) ^ 8'h5a);
        load_program();
        ref_mem    = mem;
        ref_x10    = run_model();
        model_done = 1'b1;
        repeat (4) @(posedge clk_in);
        #1 arst_n = 1'b1;
        wait (stop_seen);
        @(negedge clk_in);
        assert (dbgreg_dout == ref_x10) else begin
            $display("[ERROR] dbgreg_dout expected %h got %h", ref_x10, dbgreg_dout);
            $display("Finished with errors");
            $fatal(1);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- source/cpu.sv
/* RV32I subset core top
   fetch, decode, execute, register file and byte-bus memory controller */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       rdy_in,
    input  logic [7:0] mem_din,
    output logic [7:0] mem_dout,
    output word_t      mem_a,
    output logic       mem_wr,
    input  logic       io_buffer_full,
    output word_t      dbgreg_dout
);

    // fetch path
    mem_req_t if_req;
    logic     if_req_valid;
    logic     if_req_ready;
    logic     if_rsp_valid;
    word_t    if_rsp_data;
    logic     inst_valid;
    logic     inst_ready;
    word_t    inst;
    word_t    inst_pc;

    // decode to execute
    logic     uop_valid;
    logic     uop_ready;
    uop_t     uop;

    // register file
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    wb_t      wb;

    // data path and flush
    mem_req_t dm_req;
    logic     dm_req_valid;
    logic     dm_req_ready;
    logic     dm_rsp_valid;
    word_t    dm_rsp_data;
    logic     redirect_valid;
    word_t    redirect_pc;

    fetcher fetcher_i (
        .clk_in, .arst_n, .rdy_in,
        .redirect_valid, .redirect_pc,
        .if_req, .if_req_valid, .if_req_ready, .if_rsp_valid, .if_rsp_data,
        .inst_valid, .inst, .inst_pc, .inst_ready
    );

    decoder decoder_i (
        .clk_in, .arst_n, .rdy_in,
        .inst_valid, .inst, .inst_pc, .inst_ready,
        .redirect_valid,
        .uop_valid, .uop, .uop_ready
    );

    regfile regfile_i (
        .clk_in, .arst_n, .rdy_in,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .wb,
        .dbg_data (dbgreg_dout)
    );

    execute execute_i (
        .clk_in, .arst_n, .rdy_in,
        .uop_valid, .uop, .uop_ready,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .wb,
        .redirect_valid, .redirect_pc,
        .dm_req, .dm_req_valid, .dm_req_ready, .dm_rsp_valid, .dm_rsp_data
    );

    memctrl memctrl_i (
        .clk_in, .arst_n, .rdy_in,
        .io_buffer_full,
        .mem_din, .mem_dout, .mem_a, .mem_wr,
        .if_req, .if_req_valid, .if_req_ready, .if_rsp_valid, .if_rsp_data,
        .dm_req, .dm_req_valid, .dm_req_ready, .dm_rsp_valid, .dm_rsp_data
    );

endmodule

//--- source/memctrl.sv
/* memory controller
   data port first, words moved a byte per cycle, guarded I/O byte stores */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module memctrl import cpu_pkg::*; (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       rdy_in,
    input  logic       io_buffer_full,
    input  logic [7:0] mem_din,
    output logic [7:0] mem_dout,
    output word_t      mem_a,
    output logic       mem_wr,
    input  mem_req_t   if_req,
    input  logic       if_req_valid,
    output logic       if_req_ready,
    output logic       if_rsp_valid,
    output word_t      if_rsp_data,
    input  mem_req_t   dm_req,
    input  logic       dm_req_valid,
    output logic       dm_req_ready,
    output logic       dm_rsp_valid,
    output word_t      dm_rsp_data
);

    mc_state_e              state;
    logic [2:0]             cnt;
    mem_req_t               req;
    mem_req_t               grant;
    logic                   from_dm;
    logic                   is_io;
    logic                   rd_done;
    logic                   wr_done;
    logic [23:0]            rbuf;
    logic [`MEM_ADDR_W-1:0] cur_a;
    logic [`MEM_ADDR_W-1:0] last_a;

    assign dm_req_ready = state == mc_idle;
    assign if_req_ready = state == mc_idle && !dm_req_valid;
    assign grant        = dm_req_valid ? dm_req : if_req;
    assign is_io        = `XLEN'(grant.addr[`MEM_ADDR_W-1:0]) >= `IO_BASE;

    always_comb begin
        cur_a    = last_a;
        mem_dout = 8'h00;
        case (state)
            mc_read_byte: cur_a = req.addr[`MEM_ADDR_W-1:0] + `MEM_ADDR_W'(cnt[1:0]);
            mc_write_byte: begin
                cur_a    = req.addr[`MEM_ADDR_W-1:0] + `MEM_ADDR_W'(cnt[1:0]);
                mem_dout = req.wdata[{cnt[1:0], 3'b000} +: 8];
            end
            mc_io_wait: begin
                cur_a    = req.addr[`MEM_ADDR_W-1:0];
                mem_dout = req.wdata[7:0];
            end
            default: ;
        endcase
    end

    // while paused the bus keeps the last active address,
    // so the byte read before the pause is still there on resume
    assign mem_a  = `XLEN'(rdy_in ? cur_a : last_a);
    assign mem_wr = rdy_in && (state == mc_write_byte ||
                               (state == mc_io_wait && !io_buffer_full));

    assign rd_done = state == mc_read_byte && cnt == 3'd4;
    assign wr_done = (state == mc_write_byte && cnt == 3'd3) ||
                     (state == mc_io_wait && !io_buffer_full);

    // last byte arrives on the done cycle itself
    assign if_rsp_valid = rd_done && !from_dm;
    assign if_rsp_data  = {mem_din, rbuf};
    assign dm_rsp_valid = from_dm && (rd_done || wr_done);
    assign dm_rsp_data  = {mem_din, rbuf};

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state   <= mc_idle;
            cnt     <= 3'd0;
            from_dm <= 1'b0;
            last_a  <= '0;
        end else if (rdy_in) begin
            last_a <= cur_a;
            case (state)
                mc_idle: begin
                    cnt <= 3'd0;
                    if (dm_req_valid || if_req_valid) begin
                        from_dm <= dm_req_valid;
                        if (!grant.write)
                            state <= mc_read_byte;
                        else if (is_io)
                            state <= mc_io_wait;
                        else
                            state <= mc_write_byte;
                    end
                end
                mc_read_byte, mc_write_byte: begin
                    cnt <= cnt + 3'd1;
                    if (rd_done || wr_done)
                        state <= mc_idle;
                end
                default: begin
                    if (wr_done)
                        state <= mc_idle;
                end
            endcase
        end
    end

    // bytes 0..2 shift in little-endian, one cycle behind their address
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (state == mc_idle)
                req <= grant;
            if (state == mc_read_byte && cnt != 3'd0)
                rbuf <= {mem_din, rbuf[23:8]};
        end
    end

endmodule

//--- source/execute.sv
/* execute stage
   ALU, branch resolve, load/store issue and register write-back */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute import cpu_pkg::*; (
    input  logic     clk_in,
    input  logic     arst_n,
    input  logic     rdy_in,
    input  logic     uop_valid,
    input  uop_t     uop,
    output logic     uop_ready,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output wb_t      wb,
    output logic     redirect_valid,
    output word_t    redirect_pc,
    output mem_req_t dm_req,
    output logic     dm_req_valid,
    input  logic     dm_req_ready,
    input  logic     dm_rsp_valid,
    input  word_t    dm_rsp_data
);

    logic  busy;
    logic  is_mem;
    logic  taken;
    logic  fire;
    word_t op_b;
    word_t alu_res;

    // operands come straight from the uop held by the decoder
    assign rs1_idx = uop.rs1;
    assign rs2_idx = uop.rs2;

    assign is_mem = uop.kind == uk_load || uop.kind == uk_store;
    assign op_b   = (uop.kind == uk_alu_reg) ? rs2_data : uop.imm;

    always_comb begin
        case (uop.op)
            alu_sub:      alu_res = rs1_data - op_b;
            alu_and:      alu_res = rs1_data & op_b;
            alu_or:       alu_res = rs1_data | op_b;
            alu_xor:      alu_res = rs1_data ^ op_b;
            alu_slt:      alu_res = word_t'($signed(rs1_data) < $signed(op_b));
            alu_sll:      alu_res = rs1_data << op_b[$clog2(`XLEN)-1:0];
            alu_srl:      alu_res = rs1_data >> op_b[$clog2(`XLEN)-1:0];
            alu_pass_imm: alu_res = uop.imm;
            default:      alu_res = rs1_data + op_b;
        endcase
    end

    always_comb begin
        case (uop.kind)
            uk_branch_eq: taken = rs1_data == rs2_data;
            uk_branch_ne: taken = rs1_data != rs2_data;
            uk_jump:      taken = 1'b1;
            default:      taken = 1'b0;
        endcase
    end

    assign redirect_valid = uop_valid && taken;
    assign redirect_pc    = uop.pc + uop.imm;

    // memory ops retire on the response, everything else in one cycle
    assign uop_ready = busy ? dm_rsp_valid : !is_mem;
    assign fire      = uop_valid && uop_ready;

    assign dm_req_valid = uop_valid && !busy && is_mem;
    assign dm_req       = '{addr: rs1_data + uop.imm, wdata: rs2_data,
                            write: uop.kind == uk_store};

    always_comb begin
        wb.rd = uop.rd;
        wb.en = fire && (uop.kind == uk_alu_reg || uop.kind == uk_alu_imm ||
                         uop.kind == uk_load || uop.kind == uk_jump);
        case (uop.kind)
            uk_load: wb.data = dm_rsp_data;
            uk_jump: wb.data = uop.pc + 32'd4;
            default: wb.data = alu_res;
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n)
            busy <= 1'b0;
        else if (rdy_in) begin
            if (dm_req_valid && dm_req_ready)
                busy <= 1'b1;
            else if (busy && dm_rsp_valid)
                busy <= 1'b0;
        end
    end

endmodule

//--- source/regfile.sv
/* architectural register file
   32 x 32, two combinational reads, one write port, x0 reads zero */
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
    input  logic     clk_in,
    input  logic     arst_n,
    input  logic     rdy_in,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  wb_t      wb,
    output word_t    dbg_data
);

    word_t regs [32];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (rdy_in && wb.en && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    // a0 for the debug port
    assign dbg_data = regs[10];

endmodule

//--- source/decoder.sv
/* instruction decoder
   RV32I subset to micro-op, held in a single output register */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decoder import cpu_pkg::*; (
    input  logic  clk_in,
    input  logic  arst_n,
    input  logic  rdy_in,
    input  logic  inst_valid,
    input  word_t inst,
    input  word_t inst_pc,
    output logic  inst_ready,
    input  logic  redirect_valid,
    output logic  uop_valid,
    output uop_t  uop,
    input  logic  uop_ready
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    logic       legal;
    logic       f3_ok;
    alu_op_e    f3_op;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    uop_t       dec;
    uop_t       uop_q;
    logic       valid_q;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7_5 = inst[30];

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // shared funct3 map of the OP and OP-IMM groups
    always_comb begin
        case (funct3)
            3'b000:  f3_op = (opcode == 7'b0110011 && funct7_5) ? alu_sub : alu_add;
            3'b001:  f3_op = alu_sll;
            3'b010:  f3_op = alu_slt;
            3'b100:  f3_op = alu_xor;
            3'b101:  f3_op = alu_srl;
            3'b110:  f3_op = alu_or;
            default: f3_op = alu_and;
        endcase
        // sltu and sra are not supported
        f3_ok = funct3 != 3'b011 && !(funct3 == 3'b101 && funct7_5);
    end

    always_comb begin
        legal = 1'b1;
        dec   = '{kind: uk_alu_imm, op: alu_add, rd: inst[11:7], rs1: inst[19:15],
                  rs2: inst[24:20], imm: imm_i, pc: inst_pc};
        case (opcode)
            7'b0110111: begin
                dec.op  = alu_pass_imm;
                dec.imm = imm_u;
            end
            7'b0010011: begin
                dec.op = f3_op;
                legal  = f3_ok;
            end
            7'b0110011: begin
                dec.kind = uk_alu_reg;
                dec.op   = f3_op;
                legal    = f3_ok;
            end
            7'b0000011: begin
                dec.kind = uk_load;
                legal    = funct3 == 3'b010;
            end
            7'b0100011: begin
                dec.kind = uk_store;
                dec.imm  = imm_s;
                legal    = funct3 == 3'b010;
            end
            7'b1100011: begin
                dec.kind = funct3[0] ? uk_branch_ne : uk_branch_eq;
                dec.imm  = imm_b;
                legal    = funct3[2:1] == 2'b00;
            end
            7'b1101111: begin
                dec.kind = uk_jump;
                dec.imm  = imm_j;
            end
            default: legal = 1'b0;
        endcase
        // anything else retires as addi x0, x0, 0
        if (!legal) begin
            dec.kind = uk_alu_imm;
            dec.op   = alu_add;
            dec.rd   = 5'd0;
            dec.imm  = '0;
        end
    end

    assign inst_ready = !valid_q || uop_ready;
    assign uop_valid  = valid_q;
    assign uop        = uop_q;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n)
            valid_q <= 1'b0;
        else if (rdy_in) begin
            if (redirect_valid)
                valid_q <= 1'b0;
            else if (inst_ready)
                valid_q <= inst_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && inst_ready && inst_valid)
            uop_q <= dec;
    end

endmodule

//--- source/fetcher.sv
/* instruction fetch unit
   sequential pc, up to two requests in flight, two-entry instruction queue */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetcher import cpu_pkg::*; (
    input  logic     clk_in,
    input  logic     arst_n,
    input  logic     rdy_in,
    input  logic     redirect_valid,
    input  word_t    redirect_pc,
    output mem_req_t if_req,
    output logic     if_req_valid,
    input  logic     if_req_ready,
    input  logic     if_rsp_valid,
    input  word_t    if_rsp_data,
    output logic     inst_valid,
    output word_t    inst,
    output word_t    inst_pc,
    input  logic     inst_ready
);

    word_t      pc;
    word_t      rsp_pc;
    logic       started;
    logic [1:0] pend;
    logic [1:0] pend_next;
    logic [1:0] drop;
    logic [1:0] count;
    logic       head;
    logic       req_fire;
    logic       keep_rsp;
    logic       pop;
    word_t      q_inst [2];
    word_t      q_pc [2];

    // in-flight plus queued never exceeds the queue depth
    assign if_req_valid = started && !redirect_valid &&
                          (3'(pend) + 3'(count) < 3'd2);
    assign if_req       = '{addr: pc, wdata: '0, write: 1'b0};

    assign req_fire  = if_req_valid && if_req_ready;
    assign keep_rsp  = if_rsp_valid && drop == 2'd0 && !redirect_valid;
    assign pop       = inst_valid && inst_ready;
    assign pend_next = pend + 2'(req_fire) - 2'(if_rsp_valid);

    assign inst_valid = count != 2'd0;
    assign inst       = q_inst[head];
    assign inst_pc    = q_pc[head];

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= `RESET_PC;
            rsp_pc  <= `RESET_PC;
            started <= 1'b0;
            pend    <= 2'd0;
            drop    <= 2'd0;
            count   <= 2'd0;
            head    <= 1'b0;
        end else if (rdy_in) begin
            started <= 1'b1;
            pend    <= pend_next;
            if (redirect_valid) begin
                // everything still in flight is wrong path
                pc     <= redirect_pc;
                rsp_pc <= redirect_pc;
                drop   <= pend_next;
                count  <= 2'd0;
                head   <= 1'b0;
            end else begin
                if (req_fire)
                    pc <= pc + 32'd4;
                if (if_rsp_valid && drop != 2'd0)
                    drop <= drop - 2'd1;
                if (keep_rsp)
                    rsp_pc <= rsp_pc + 32'd4;
                count <= count + 2'(keep_rsp) - 2'(pop);
                if (pop)
                    head <= !head;
            end
        end
    end

    // tail slot sits one past head when an entry is waiting
    always_ff @(posedge clk_in) begin
        if (rdy_in && keep_rsp) begin
            q_inst[head ^ count[0]] <= if_rsp_data;
            q_pc[head ^ count[0]]   <= rsp_pc;
        end
    end

endmodule

//--- source/cpu_pkg.sv
/* shared types of the core
   stage payloads, opcodes and memctrl states */
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_idx_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_pass_imm
    } alu_op_e;

    typedef enum logic [2:0] {
        uk_alu_reg,
        uk_alu_imm,
        uk_load,
        uk_store,
        uk_branch_eq,
        uk_branch_ne,
        uk_jump
    } uop_kind_e;

    typedef enum logic [1:0] {
        mc_idle,
        mc_read_byte,
        mc_write_byte,
        mc_io_wait
    } mc_state_e;

    // one decoded instruction
    typedef struct packed {
        uop_kind_e kind;
        alu_op_e   op;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;
        word_t     pc;
    } uop_t;

    // one word request to memctrl
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;
    } mem_req_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

//--- source/cpu_defs.svh
/* core-wide constants
   data width, reset vector and the byte bus memory map */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and address width
`define XLEN         32

// first fetch address
`define RESET_PC     32'h0000_0000

// address bits actually decoded on the bus
`define MEM_ADDR_W   18

// I/O region starts where bits 17:16 are both set
`define IO_BASE      32'h0003_0000

// a store here ends the program
`define IO_STOP_ADDR 32'h0003_0004

`endif
